// File: include/fb_macros.svh
// --------------------------------------------------------------------------
// framebuffer video geometry: 640x480 60 Hz display timing and 160x120
// 1-bit framebuffer size
// --------------------------------------------------------------------------
`ifndef FB_MACROS_SVH
`define FB_MACROS_SVH

`define FB_WIDTH  160
`define FB_HEIGHT 120
`define FB_PIXELS 19200   // FB_WIDTH * FB_HEIGHT
`define FB_ADDRW  15

// horizontal timing in pixels
`define H_ACTIVE  640
`define H_FP      16
`define H_SYNC    96
`define H_BP      48
`define H_TOTAL   800

// vertical timing in lines
`define V_ACTIVE  480
`define V_FP      10
`define V_SYNC    2
`define V_BP      33
`define V_TOTAL   525

`define CORDW     10

`endif

// File: rtl/fb_pkg.sv
// --------------------------------------------------------------------------
// framebuffer video types: display timing bundle, framebuffer write
// and 12-bit colour
// --------------------------------------------------------------------------
`default_nettype none

`include "fb_macros.svh"

package fb_pkg;

    typedef struct packed {
        logic [`CORDW-1:0] sx;  // screen x
        logic [`CORDW-1:0] sy;  // screen y
        logic hsync;            // active low
        logic vsync;            // active low
        logic de;
        logic frame;            // start of vertical blanking
    } timing_t;

    typedef struct packed {
        logic we;
        logic [`FB_ADDRW-1:0] addr;
        logic colr;             // 1-bit pixel
    } fb_wr_t;

    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

endpackage

`default_nettype wire

// File: rtl/display_timings.sv
// --------------------------------------------------------------------------
// 640x480 60 Hz display timing: screen position counters, sync pulses,
// data enable and the frame strobe at the start of vertical blanking
// --------------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "fb_macros.svh"

module display_timings
    import fb_pkg::*;
(
    input  wire logic clk_pix,
    input  wire logic rst_n,
    output timing_t   timing
);

    localparam logic [`CORDW-1:0] H_LAST  = `CORDW'(`H_TOTAL - 1);
    localparam logic [`CORDW-1:0] V_LAST  = `CORDW'(`V_TOTAL - 1);
    localparam logic [`CORDW-1:0] HS_BEG  = `CORDW'(`H_ACTIVE + `H_FP);
    localparam logic [`CORDW-1:0] HS_END  = `CORDW'(`H_ACTIVE + `H_FP + `H_SYNC);
    localparam logic [`CORDW-1:0] VS_BEG  = `CORDW'(`V_ACTIVE + `V_FP);
    localparam logic [`CORDW-1:0] VS_END  = `CORDW'(`V_ACTIVE + `V_FP + `V_SYNC);
    localparam logic [`CORDW-1:0] H_ACT   = `CORDW'(`H_ACTIVE);
    localparam logic [`CORDW-1:0] V_ACT   = `CORDW'(`V_ACTIVE);

    logic [`CORDW-1:0] sx;
    logic [`CORDW-1:0] sy;

    // back porch is whatever remains of the line after active, fp and sync
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            sx <= '0;
            sy <= '0;
        end else if (sx == H_LAST) begin
            sx <= '0;
            if (sy == V_LAST) begin
                sy <= '0;
            end else begin
                sy <= sy + 1'b1;
            end
        end else begin
            sx <= sx + 1'b1;
        end
    end

    always_comb begin
        timing.sx    = sx;
        timing.sy    = sy;
        timing.hsync = ~(sx >= HS_BEG && sx < HS_END);  // negative polarity
        timing.vsync = ~(sy >= VS_BEG && sy < VS_END);
        timing.de    = (sx < H_ACT) && (sy < V_ACT);
        timing.frame = (sx == '0) && (sy == V_ACT);     // first pixel of line 480
    end

endmodule

`default_nettype wire

// File: rtl/box_drawer.sv
// --------------------------------------------------------------------------
// box drawer: on request, writes a one-pixel border around the
// framebuffer during the next vertical blanking, in white or black
// --------------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "fb_macros.svh"

module box_drawer
    import fb_pkg::*;
(
    input  wire logic clk_pix,
    input  wire logic rst_n,
    input  wire logic box_req,
    input  wire logic box_on,
    input  wire logic frame,
    output fb_wr_t    fb_wr
);

    localparam logic [7:0] X_LAST = 8'(`FB_WIDTH - 1);
    localparam logic [7:0] Y_LAST = 8'(`FB_HEIGHT - 2);  // columns skip the top row
    localparam logic [`FB_ADDRW-1:0] ROW_STEP  = `FB_ADDRW'(`FB_WIDTH);
    localparam logic [`FB_ADDRW-1:0] RIGHT_BEG = `FB_ADDRW'(2 * `FB_WIDTH - 1);
    localparam logic [`FB_ADDRW-1:0] BOT_BEG   = `FB_ADDRW'((`FB_HEIGHT - 1) * `FB_WIDTH);

    typedef enum logic [2:0] {
        DRAW_IDLE,
        DRAW_TOP,
        DRAW_RIGHT,
        DRAW_LEFT,
        DRAW_BOTTOM
    } draw_state_e;

    draw_state_e state;
    logic [7:0] cnt;                  // step along the current edge
    logic pending;
    logic pend_colr;
    logic draw_colr;
    logic [`FB_ADDRW-1:0] addr;

    logic start;
    assign start = (state == DRAW_IDLE) && frame && pending;

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            state   <= DRAW_IDLE;
            cnt     <= '0;
            pending <= 1'b0;
        end else begin
            if (start) pending <= 1'b0;
            if (box_req) pending <= 1'b1;  // newest request wins
            cnt <= cnt + 1'b1;
            case (state)
                DRAW_IDLE: begin
                    cnt <= '0;
                    if (start) state <= DRAW_TOP;
                end
                DRAW_TOP:    if (cnt == X_LAST) begin state <= DRAW_RIGHT; cnt <= '0; end
                DRAW_RIGHT:  if (cnt == Y_LAST) begin state <= DRAW_LEFT; cnt <= '0; end
                DRAW_LEFT:   if (cnt == Y_LAST) begin state <= DRAW_BOTTOM; cnt <= '0; end
                DRAW_BOTTOM: if (cnt == X_LAST) state <= DRAW_IDLE;
                default:     state <= DRAW_IDLE;
            endcase
        end
    end

    // write address and colours
    always_ff @(posedge clk_pix) begin
        if (box_req) pend_colr <= box_on;
        if (start) draw_colr <= pend_colr;
        case (state)
            DRAW_IDLE:   addr <= '0;
            DRAW_TOP:    addr <= (cnt == X_LAST) ? RIGHT_BEG : addr + 1'b1;
            DRAW_RIGHT:  addr <= (cnt == Y_LAST) ? ROW_STEP : addr + ROW_STEP;
            DRAW_LEFT:   addr <= (cnt == Y_LAST) ? BOT_BEG : addr + ROW_STEP;
            default:     addr <= addr + 1'b1;  // bottom row
        endcase
    end

    always_comb begin
        fb_wr.we   = (state != DRAW_IDLE);
        fb_wr.addr = addr;
        fb_wr.colr = draw_colr;
    end

endmodule

`default_nettype wire

// File: rtl/fb_ram.sv
// --------------------------------------------------------------------------
// framebuffer RAM: simple dual-port, 1 bit per pixel, registered read
// --------------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "fb_macros.svh"

module fb_ram
    import fb_pkg::*;
(
    input  wire logic                 clk_pix,
    input  wire fb_wr_t               fb_wr,
    input  wire logic [`FB_ADDRW-1:0] rd_addr,
    output logic                      rd_data
);

    logic mem [`FB_PIXELS];

    // screen starts black
    initial begin
        for (int i = 0; i < `FB_PIXELS; i++) begin
            mem[i] = 1'b0;
        end
    end

    always @(posedge clk_pix) begin
        if (fb_wr.we) mem[fb_wr.addr] <= fb_wr.colr;
    end

    always_ff @(posedge clk_pix) begin
        rd_data <= mem[rd_addr];  // one cycle read latency
    end

endmodule

`default_nettype wire

// File: rtl/fb_scanout.sv
// --------------------------------------------------------------------------
// framebuffer scanout: reads pixels in step with the display position
// and registers sync, data enable and 12-bit colour
// --------------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "fb_macros.svh"

module fb_scanout
    import fb_pkg::*;
(
    input  wire logic                 clk_pix,
    input  wire logic                 rst_n,
    input  wire timing_t              timing,
    output logic [`FB_ADDRW-1:0]      rd_addr,
    input  wire logic                 rd_data,
    output logic                      hsync,
    output logic                      vsync,
    output logic                      de,
    output rgb_t                      colr
);

    logic paint;      // inside the top-left framebuffer area
    logic paint_p1;
    logic hsync_p1;
    logic vsync_p1;
    logic de_p1;

    assign paint = (timing.sx < `CORDW'(`FB_WIDTH)) && (timing.sy < `CORDW'(`FB_HEIGHT));

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            rd_addr <= '0;
        end else if (timing.frame) begin
            rd_addr <= '0;
        end else if (paint) begin
            rd_addr <= rd_addr + 1'b1;
        end
    end

    // align with RAM read, then output register
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            paint_p1 <= 1'b0;
            hsync_p1 <= 1'b1;
            vsync_p1 <= 1'b1;
            de_p1    <= 1'b0;
            hsync    <= 1'b1;
            vsync    <= 1'b1;
            de       <= 1'b0;
            colr     <= '0;
        end else begin
            paint_p1 <= paint;
            hsync_p1 <= timing.hsync;
            vsync_p1 <= timing.vsync;
            de_p1    <= timing.de;
            hsync    <= hsync_p1;
            vsync    <= vsync_p1;
            de       <= de_p1;
            colr     <= (paint_p1 && rd_data) ? '{4'hF, 4'hF, 4'hF} : '0;  // white or black
        end
    end

endmodule

`default_nettype wire

// File: rtl/fb_display_top.sv
// --------------------------------------------------------------------------
// framebuffer display top: timing generator, box drawer, framebuffer
// RAM and scanout for a 640x480 output
// --------------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "fb_macros.svh"

module fb_display_top
    import fb_pkg::*;
(
    input  wire logic clk_pix,
    input  wire logic rst_n,
    input  wire logic box_req,  // single-cycle request strobe
    input  wire logic box_on,   // 1 draws, 0 erases
    output logic      hsync,
    output logic      vsync,
    output logic      de,
    output rgb_t      colr
);

    timing_t timing;
    fb_wr_t  fb_wr;
    logic [`FB_ADDRW-1:0] rd_addr;
    logic rd_data;

    display_timings u_display_timings (
        .clk_pix (clk_pix),
        .rst_n   (rst_n),
        .timing  (timing)
    );

    box_drawer u_box_drawer (
        .clk_pix (clk_pix),
        .rst_n   (rst_n),
        .box_req (box_req),
        .box_on  (box_on),
        .frame   (timing.frame),
        .fb_wr   (fb_wr)
    );

    fb_ram u_fb_ram (
        .clk_pix (clk_pix),
        .fb_wr   (fb_wr),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    fb_scanout u_fb_scanout (
        .clk_pix (clk_pix),
        .rst_n   (rst_n),
        .timing  (timing),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .hsync   (hsync),
        .vsync   (vsync),
        .de      (de),
        .colr    (colr)
    );

endmodule

`default_nettype wire

// File: test/fb_display_checker.sv
// --------------------------------------------------------------------------
// framebuffer display checker: tracks the output position, models box
// requests and compares sync, data enable and colour
// --------------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "fb_macros.svh"

module fb_display_checker
    import fb_pkg::*;
(
    input  wire logic clk_pix,
    input  wire logic rst_n,
    input  wire logic box_req,
    input  wire logic box_on,
    input  wire logic hsync,
    input  wire logic vsync,
    input  wire logic de,
    input  wire rgb_t colr,
    output int        err_cnt,
    output int        chk_cnt
);

    int n_err = 0;
    int n_chk = 0;
    int x = 0;
    int y = 0;
    int post_rst = 0;
    int hs_cnt = 0;
    int hs_low = 0;
    int vs_low = 0;
    logic hs_seen = 1'b0;
    logic pend = 1'b0;
    logic pend_on = 1'b0;
    logic box_vis = 1'b0;     // box state shown in the current frame
    logic de_q = 1'b0;
    logic hs_q = 1'b1;
    logic vs_q = 1'b1;

    assign err_cnt = n_err;
    assign chk_cnt = n_chk;

    function automatic rgb_t expected_pixel(int px, int py, logic vis);
        logic in_fb;
        logic on_border;
        in_fb     = (px < `FB_WIDTH) && (py < `FB_HEIGHT);
        on_border = (px == 0) || (px == `FB_WIDTH - 1) || (py == 0) || (py == `FB_HEIGHT - 1);
        return (vis && in_fb && on_border) ? rgb_t'(12'hfff) : rgb_t'(12'h000);
    endfunction

    task automatic check_value(string name, int got, int exp);
        n_chk++;
        if (got != exp) begin
            n_err++;
            $display("** Error at %0d ns: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_colour(int px, int py, rgb_t got, rgb_t exp);
        n_chk++;
        if (got !== exp) begin
            n_err++;
            $display("** Error at %0d ns: colr at x=%0d y=%0d is %h, expected %h",
                     $time, px, py, got, exp);
        end
    endtask

    task automatic check_idle_outputs();
        check_value("hsync", int'(hsync), 1);
        check_value("vsync", int'(vsync), 1);
        check_value("de", int'(de), 0);
        check_value("colr", int'(colr), 0);
    endtask

    // outputs change on the rising edge, so sample on the falling one
    always @(negedge clk_pix) begin
        if (!rst_n) begin
            post_rst = 0;
            pend     = 1'b0;
            check_idle_outputs();
        end else begin
            if (post_rst < 2) begin   // pipeline still holds reset values
                check_idle_outputs();
                post_rst++;
            end
            if (box_req) begin
                pend    = 1'b1;
                pend_on = box_on;
            end
            if (de) begin
                x = de_q ? x + 1 : 0;
                check_colour(x, y, colr, expected_pixel(x, y, box_vis));
            end
            if (!de && de_q) begin
                check_value("de length", x + 1, `H_ACTIVE);
                y++;
                if (y == `V_ACTIVE && pend) begin   // frame strobe follows the last line
                    box_vis = pend_on;
                    pend    = 1'b0;
                end
            end
            if (!hsync && hs_q) begin
                if (hs_seen) check_value("hsync period", hs_cnt, `H_TOTAL);
                hs_seen = 1'b1;
                hs_cnt  = 0;
                hs_low  = 0;
            end
            hs_cnt++;
            if (!hsync) hs_low++;
            if (hsync && !hs_q) check_value("hsync low width", hs_low, `H_SYNC);
            if (!vsync && vs_q) begin
                check_value("lines with de", y, `V_ACTIVE);
                y      = 0;
                vs_low = 0;
            end
            if (!vsync) vs_low++;
            if (vsync && !vs_q) check_value("vsync low width", vs_low, `V_SYNC * `H_TOTAL);
            de_q = de;
            hs_q = hsync;
            vs_q = vsync;
        end
    end

endmodule

`default_nettype wire

// File: test/tb_fb_display.sv
// --------------------------------------------------------------------------
// framebuffer display testbench: clock, reset, box requests, DUT and
// checker instances, run length and timeout
// --------------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "fb_macros.svh"

module tb_fb_display
    import fb_pkg::*;
();

    localparam int FRAME_CYC   = `H_TOTAL * `V_TOTAL;
    localparam int RUN_CYC     = 5 * FRAME_CYC + 20;      // five frames and the pipeline tail
    localparam int TIMEOUT_CYC = 5 * FRAME_CYC + 100_000;

    logic clk_pix;
    logic rst_n;
    logic box_req;
    logic box_on;
    logic hsync;
    logic vsync;
    logic de;
    rgb_t colr;
    int err_cnt;
    int chk_cnt;
    int cyc = 0;            // equals the screen position index since reset

    initial begin
        clk_pix = 1'b0;
        forever #10 clk_pix = ~clk_pix;
    end

    always @(posedge clk_pix) begin
        if (rst_n) cyc <= cyc + 1;
    end

    // one-cycle request at a given frame, line and column
    task automatic issue_request(int frame_no, int line, int col, logic on);
        int target;
        target = frame_no * FRAME_CYC + line * `H_TOTAL + col;
        while (cyc < target) begin
            @(posedge clk_pix);
            #2;
        end
        box_req = 1'b1;
        box_on  = on;
        @(posedge clk_pix);
        #2;
        box_req = 1'b0;
    endtask

    fb_display_top u_fb_display_top (
        .clk_pix (clk_pix),
        .rst_n   (rst_n),
        .box_req (box_req),
        .box_on  (box_on),
        .hsync   (hsync),
        .vsync   (vsync),
        .de      (de),
        .colr    (colr)
    );

    fb_display_checker u_checker (
        .clk_pix (clk_pix),
        .rst_n   (rst_n),
        .box_req (box_req),
        .box_on  (box_on),
        .hsync   (hsync),
        .vsync   (vsync),
        .de      (de),
        .colr    (colr),
        .err_cnt (err_cnt),
        .chk_cnt (chk_cnt)
    );

    initial begin
        void'($urandom(32'ha19e_6337));
        rst_n   = 1'b0;
        box_req = 1'b0;
        box_on  = 1'b0;
        repeat (5) @(posedge clk_pix);
        #2 rst_n = 1'b1;
        // frame 1: a request that the draw request then replaces
        issue_request(1, 40 + int'($urandom % 160), 100 + int'($urandom % 400),
                      1'($urandom % 2));
        issue_request(1, 240 + int'($urandom % 160), 100 + int'($urandom % 400), 1'b1);
        issue_request(3, 40 + int'($urandom % 360), 100 + int'($urandom % 400), 1'b0);
        while (cyc < RUN_CYC) begin
            @(posedge clk_pix);
            #2;
        end
        $display("checks: %0d  errors: %0d", chk_cnt, err_cnt);
        if (err_cnt == 0 && chk_cnt > 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        repeat (TIMEOUT_CYC) @(posedge clk_pix);
        $display("timeout: the run did not end within %0d cycles", TIMEOUT_CYC);
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
+incdir+include
rtl/fb_pkg.sv
rtl/display_timings.sv
rtl/box_drawer.sv
rtl/fb_ram.sv
rtl/fb_scanout.sv
rtl/fb_display_top.sv
test/fb_display_checker.sv
test/tb_fb_display.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the framebuffer display testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_fb_display \
    -f build.f -Mdir obj_dir -o sim_fb_display > build.log 2>&1 \
    && ./obj_dir/sim_fb_display > sim.log 2>&1 \
    || { cat build.log; echo "build or run did not complete"; exit 1; }

cat sim.log
grep -q "Something failed" sim.log && { echo "result: FAIL"; exit 1; } || echo "result: PASS"
